// File: Bender.yml
package:
  name: mem_arbiter

sources:
  - include_dirs:
      - design
    files:
      - design/mem_arb_pkg.sv
      - design/ram_if.sv
      - design/req_if.sv
      - design/requester_port.sv
      - design/memory_arbiter.sv
      - design/main_memory.sv
      - design/mem_arbiter_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/mem_arbiter_sva.sv
      - bench/mem_arbiter_tb.sv

// File: bench/mem_arbiter_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_sva
  import mem_arb_pkg::*;
(
  input logic       CLK,
  input logic       nRST,
  input arb_state_e state,
  input logic       REN,
  input logic       WEN,
  input logic       ramhit,
  input addr_t      sel,
  input word_t      wdat,
  input logic       sp_done,
  input logic       dc_done,
  input logic       ic_done
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  a_strobe_excl: assert property (@(posedge CLK) disable iff (!nRST) !(REN && WEN))
    else begin
      $error("REN and WEN are high in the same cycle");
      fail_count++;
    end

  a_hit_under_strobe: assert property (@(posedge CLK) disable iff (!nRST)
    ramhit |-> (REN || WEN))
    else begin
      $error("ramhit without a strobe");
      fail_count++;
    end

  // Beat must hold its strobe, address and data until ramhit
  a_beat_stable: assert property (@(posedge CLK) disable iff (!nRST)
    ((REN || WEN) && !ramhit) |=> ((REN || WEN) && $stable(sel) && $stable(wdat)))
    else begin
      $error("strobe, sel or wdat changed while waiting for ramhit");
      fail_count++;
    end

  a_one_done: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({sp_done, dc_done, ic_done}))
    else begin
      $error("more than one done pulse in a cycle");
      fail_count++;
    end

  a_idle_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> (state == IDLE))
    else begin
      $error("arbiter not in IDLE when reset is released");
      fail_count++;
    end

endmodule

bind memory_arbiter mem_arbiter_sva sva_inst (
  .CLK     (CLK),
  .nRST    (nRST),
  .state   (state),
  .REN     (ram.REN),
  .WEN     (ram.WEN),
  .ramhit  (ram.ramhit),
  .sel     (ram.sel),
  .wdat    (ram.wdat),
  .sp_done (sp.done),
  .dc_done (dc.done),
  .ic_done (ic.done)
);

`default_nettype wire

// File: bench/mem_arbiter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_settings.svh"

module mem_arbiter_tb
  import mem_arb_pkg::*;
();

  localparam int SP = 0;
  localparam int DC = 1;
  localparam int IC = 2;
  localparam int NUM_TESTS = 5;
  localparam int REQ_PER_TEST = 200;
  localparam int WAIT_LIMIT = 8 * (`RAM_LATENCY + 4);
  localparam longint TIMEOUT_NS =
    longint'(NUM_TESTS) * REQ_PER_TEST * 4 * (`RAM_LATENCY + 4) * 40;

  logic   CLK;
  logic   nRST;
  logic   sp_load;
  logic   sp_store;
  addr_t  sp_addr;
  dword_t sp_store_data;
  dword_t sp_load_data;
  logic   sp_wait;
  logic   dreq;
  logic   dwen;
  addr_t  daddr;
  word_t  dstore;
  word_t  dload;
  logic   dwait;
  logic   ireq;
  addr_t  iaddr;
  word_t  iload;
  logic   iwait;

  // Reference memory, written as the bench issues stores
  word_t ref_mem [`MEM_WORDS];
  bit    ref_valid [`MEM_WORDS];

  string test_name;
  int    errors;
  int    errors_at_start;
  int    pass_count;
  int    fail_count;

  mem_arbiter_top mem_arbiter_top_inst (
    .CLK           (CLK),
    .nRST          (nRST),
    .sp_load       (sp_load),
    .sp_store      (sp_store),
    .sp_addr       (sp_addr),
    .sp_store_data (sp_store_data),
    .sp_load_data  (sp_load_data),
    .sp_wait       (sp_wait),
    .dreq          (dreq),
    .dwen          (dwen),
    .daddr         (daddr),
    .dstore        (dstore),
    .dload         (dload),
    .dwait         (dwait),
    .ireq          (ireq),
    .iaddr         (iaddr),
    .iload         (iload),
    .iwait         (iwait)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
    $display("TEST FAIL");
    $finish;
  end

  // Word index, upper address bits wrap like the memory
  function automatic int widx(input addr_t a);
    return int'((a >> 2) % `MEM_WORDS);
  endfunction

  function automatic logic wait_of(input int c);
    case (c)
      SP: return sp_wait;
      DC: return dwait;
      default: return iwait;
    endcase
  endfunction

  function automatic dword_t load_of(input int c);
    case (c)
      SP: return sp_load_data;
      DC: return {32'h0, dload};
      default: return {32'h0, iload};
    endcase
  endfunction

  // Scratchpad low word at the address, high word at address plus 4
  function automatic dword_t ref_read(input int c, input addr_t a);
    if (c == SP) begin
      return {ref_mem[widx(a + addr_t'(4))], ref_mem[widx(a)]};
    end
    return {32'h0, ref_mem[widx(a)]};
  endfunction

  task automatic ref_write(input int c, input addr_t a, input dword_t d);
    ref_mem[widx(a)]   = d[31:0];
    ref_valid[widx(a)] = 1'b1;
    if (c == SP) begin
      ref_mem[widx(a + addr_t'(4))]   = d[63:32];
      ref_valid[widx(a + addr_t'(4))] = 1'b1;
    end
  endtask

  task automatic check_value(input dword_t exp, input dword_t act);
    assert (act === exp)
      else begin
        $display("** Error %s: expected %h, actual %h", test_name, exp, act);
        errors++;
      end
  endtask

  // Call right after a rising edge
  task automatic start_req(input int c, input logic write, input addr_t a, input dword_t d);
    case (c)
      SP: begin
        sp_load       <= !write;
        sp_store      <= write;
        sp_addr       <= a;
        sp_store_data <= d;
      end
      DC: begin
        dreq   <= 1'b1;
        dwen   <= write;
        daddr  <= a;
        dstore <= d[31:0];
      end
      default: begin
        ireq  <= 1'b1;
        iaddr <= a;
      end
    endcase
  endtask

  task automatic clear_reqs();
    sp_load  <= 1'b0;
    sp_store <= 1'b0;
    dreq     <= 1'b0;
    dwen     <= 1'b0;
    ireq     <= 1'b0;
  endtask

  // Returns on the falling edge after wait has dropped
  task automatic await_done(input int c);
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (wait_of(c) && n < WAIT_LIMIT);
    assert (!wait_of(c))
      else begin
        $display("%s: wait of client %0d still high after %0d cycles", test_name, c, n);
        errors++;
      end
  endtask

  task automatic access(input int c, input logic write, input addr_t a, input dword_t d);
    @(posedge CLK);
    start_req(c, write, a, d);
    @(posedge CLK);
    clear_reqs();
    await_done(c);
    if (write) begin
      ref_write(c, a, d);
    end else begin
      check_value(ref_read(c, a), load_of(c));
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      pass_count++;
      $display("[%s] passed", test_name);
    end else begin
      fail_count++;
      $display("[%s] failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  initial begin
    int          c;
    logic        write;
    logic        known;
    addr_t       a;
    dword_t      d;
    int          fall [3];
    int          n;
    int unsigned sva_fails;

    void'($urandom(32'h29c8));
    errors        = 0;
    pass_count    = 0;
    fail_count    = 0;
    nRST          = 1'b0;
    sp_load       = 1'b0;
    sp_store      = 1'b0;
    sp_addr       = '0;
    sp_store_data = '0;
    dreq          = 1'b0;
    dwen          = 1'b0;
    daddr         = '0;
    dstore        = '0;
    ireq          = 1'b0;
    iaddr         = '0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;

    begin_test("reset");
    @(negedge CLK);
    assert (!sp_wait && !dwait && !iwait)
      else begin
        $display("%s: a wait is high after reset", test_name);
        errors++;
      end
    check_value('0, sp_load_data);
    check_value('0, {32'h0, dload});
    check_value('0, {32'h0, iload});
    end_test();

    begin_test("dcache_write_read");
    access(DC, 1'b1, 32'h40, 64'h0000_0000_cafe_0123);
    access(DC, 1'b0, 32'h40, '0);
    access(IC, 1'b0, 32'h40, '0);
    end_test();

    begin_test("sp_store_load");
    access(SP, 1'b1, 32'h80, 64'h1122_3344_5566_7788);
    access(SP, 1'b0, 32'h80, '0);
    access(DC, 1'b0, 32'h80, '0);
    access(DC, 1'b0, 32'h84, '0);
    end_test();

    // Three clients request in the same cycle
    begin_test("priority");
    @(posedge CLK);
    start_req(SP, 1'b0, 32'h80, '0);
    start_req(DC, 1'b0, 32'h40, '0);
    start_req(IC, 1'b0, 32'h84, '0);
    @(posedge CLK);
    clear_reqs();
    fall = '{-1, -1, -1};
    n    = 0;
    do begin
      @(negedge CLK);
      n++;
      for (int k = 0; k < 3; k++) begin
        if (fall[k] < 0 && !wait_of(k)) begin
          fall[k] = n;
        end
      end
    end while ((sp_wait || dwait || iwait) && n < 3 * WAIT_LIMIT);
    assert (fall[0] > 0 && fall[0] < fall[1] && fall[1] < fall[2])
      else begin
        $display("%s: waits fell out of order or never (sp %0d, dcache %0d, icache %0d)",
                 test_name, fall[0], fall[1], fall[2]);
        errors++;
      end
    check_value(ref_read(SP, 32'h80), load_of(SP));
    check_value(ref_read(DC, 32'h40), load_of(DC));
    check_value(ref_read(IC, 32'h84), load_of(IC));
    end_test();

    begin_test("random");
    for (int i = 0; i < REQ_PER_TEST; i++) begin
      c     = $urandom_range(0, 2);
      write = (c != IC) && ($urandom_range(0, 1) == 1);
      a     = addr_t'($urandom_range(0, `MEM_WORDS - 1)) << 2;
      d     = {$urandom, $urandom};
      // Reads only touch words the bench has written
      known = ref_valid[widx(a)] && (c != SP || ref_valid[widx(a + addr_t'(4))]);
      if (!write && !known) begin
        write = 1'b1;
        if (c == IC) begin
          c = DC;
        end
      end
      repeat ($urandom_range(0, 3)) @(posedge CLK);
      access(c, write, a, d);
    end
    end_test();

    sva_fails = mem_arbiter_top_inst.arbiter_inst.sva_inst.fail_count;
    $display("Tests passed: %0d, failed: %0d, protocol assertion failures: %0d",
             pass_count, fail_count, sva_fails);
    if (fail_count == 0 && sva_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+design
design/mem_arb_pkg.sv
design/ram_if.sv
design/req_if.sv
design/requester_port.sv
design/memory_arbiter.sv
design/main_memory.sv
design/mem_arbiter_top.sv
bench/mem_arbiter_sva.sv
bench/mem_arbiter_tb.sv

// File: design/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_arb_settings.svh"

module main_memory
  import mem_arb_pkg::*;
#(
  parameter int DEPTH   = `MEM_WORDS,
  parameter int LATENCY = `RAM_LATENCY
) (
  input logic   CLK,
  input logic   nRST,
  ram_if.memory ram
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(LATENCY + 1);

  word_t            mem [DEPTH];
  logic [CNT_W-1:0] cnt;
  logic             hit;
  logic             strobe;
  logic             expire;
  logic [IDX_W-1:0] idx;

  assign strobe = ram.REN || ram.WEN;
  // Last waiting cycle of the current beat
  assign expire = strobe && !hit && (cnt == CNT_W'(LATENCY - 1));
  // Upper address bits are ignored
  assign idx    = ram.sel[IDX_W-1:0];

  // Counter restarts after each ramhit, so back to back beats work
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt <= '0;
      hit <= 1'b0;
    end else if (!strobe || hit) begin
      cnt <= '0;
      hit <= 1'b0;
    end else if (expire) begin
      cnt <= '0;
      hit <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (expire && ram.WEN) begin
      mem[idx] <= ram.wdat;
    end
    if (expire && ram.REN) begin
      ram.rdat <= mem[idx];
    end
  end

  assign ram.ramhit = hit;

endmodule

`default_nettype wire

// File: design/mem_arb_pkg.sv
`default_nettype none

`include "mem_arb_settings.svh"

package mem_arb_pkg;

  // RAM and cache datum
  typedef logic [31:0] word_t;

  // Scratchpad datum, high word at address plus 4
  typedef logic [63:0] dword_t;

  // Byte address, word aligned
  typedef logic [`ADDR_W-1:0] addr_t;

  // Arbiter states, one per RAM beat kind
  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    SP_LOAD_LO  = 3'd1,
    SP_LOAD_HI  = 3'd2,
    SP_STORE_LO = 3'd3,
    SP_STORE_HI = 3'd4,
    DCACHE      = 3'd5,
    ICACHE      = 3'd6
  } arb_state_e;

endpackage

`default_nettype wire

// File: design/mem_arb_settings.svh
`ifndef MEM_ARB_SETTINGS_SVH
`define MEM_ARB_SETTINGS_SVH

// Main memory depth in 32-bit words
`define MEM_WORDS 256

// Cycles from the first strobe cycle to ramhit
`define RAM_LATENCY 2

// Byte address width seen by all clients
`define ADDR_W 32

`endif

// File: design/mem_arbiter_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_top
  import mem_arb_pkg::*;
(
  input  logic   CLK,
  input  logic   nRST,
  // Scratchpad
  input  logic   sp_load,
  input  logic   sp_store,
  input  addr_t  sp_addr,
  input  dword_t sp_store_data,
  output dword_t sp_load_data,
  output logic   sp_wait,
  // Data cache
  input  logic   dreq,
  input  logic   dwen,
  input  addr_t  daddr,
  input  word_t  dstore,
  output word_t  dload,
  output logic   dwait,
  // Instruction cache
  input  logic   ireq,
  input  addr_t  iaddr,
  output word_t  iload,
  output logic   iwait
);

  req_if #(.data_t(dword_t)) sp_link ();
  req_if #(.data_t(word_t))  dc_link ();
  req_if #(.data_t(word_t))  ic_link ();
  ram_if                     ram_bus ();

  // Load and store share one request, store selects the write
  requester_port #(.data_t(dword_t)) sp_port_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (sp_load || sp_store),
    .wen         (sp_store),
    .addr        (sp_addr),
    .wdata       (sp_store_data),
    .rdata       (sp_load_data),
    .client_wait (sp_wait),
    .link        (sp_link)
  );

  requester_port #(.data_t(word_t)) dc_port_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (dreq),
    .wen         (dwen),
    .addr        (daddr),
    .wdata       (dstore),
    .rdata       (dload),
    .client_wait (dwait),
    .link        (dc_link)
  );

  // Instruction fetch never writes
  requester_port #(.data_t(word_t)) ic_port_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .req         (ireq),
    .wen         (1'b0),
    .addr        (iaddr),
    .wdata       ('0),
    .rdata       (iload),
    .client_wait (iwait),
    .link        (ic_link)
  );

  memory_arbiter arbiter_inst (
    .CLK  (CLK),
    .nRST (nRST),
    .sp   (sp_link),
    .dc   (dc_link),
    .ic   (ic_link),
    .ram  (ram_bus)
  );

  main_memory memory_inst (
    .CLK  (CLK),
    .nRST (nRST),
    .ram  (ram_bus)
  );

endmodule

`default_nettype wire

// File: design/memory_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter
  import mem_arb_pkg::*;
(
  input logic    CLK,
  input logic    nRST,
  req_if.arbiter sp,
  req_if.arbiter dc,
  req_if.arbiter ic,
  ram_if.arbiter ram
);

  arb_state_e state;
  arb_state_e state_next;

  // Byte address of the current beat
  addr_t beat_addr;
  // Low word of a scratchpad load, kept for the high beat
  word_t lo_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Fixed priority, evaluated only in IDLE
  always_comb begin
    state_next = state;
    unique case (state)
      IDLE: begin
        if (sp.pending && !sp.wen) begin
          state_next = SP_LOAD_LO;
        end else if (sp.pending && sp.wen) begin
          state_next = SP_STORE_LO;
        end else if (dc.pending) begin
          state_next = DCACHE;
        end else if (ic.pending) begin
          state_next = ICACHE;
        end
      end
      SP_LOAD_LO: begin
        if (ram.ramhit) begin
          state_next = SP_LOAD_HI;
        end
      end
      SP_STORE_LO: begin
        if (ram.ramhit) begin
          state_next = SP_STORE_HI;
        end
      end
      SP_LOAD_HI, SP_STORE_HI, DCACHE, ICACHE: begin
        if (ram.ramhit) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // Strobe, address and write data for the current beat
  always_comb begin
    ram.REN   = 1'b0;
    ram.WEN   = 1'b0;
    ram.wdat  = '0;
    beat_addr = '0;
    unique case (state)
      SP_LOAD_LO: begin
        ram.REN   = 1'b1;
        beat_addr = sp.addr;
      end
      SP_LOAD_HI: begin
        ram.REN   = 1'b1;
        beat_addr = sp.addr + addr_t'(4);
      end
      SP_STORE_LO: begin
        ram.WEN   = 1'b1;
        ram.wdat  = sp.wdata[31:0];
        beat_addr = sp.addr;
      end
      SP_STORE_HI: begin
        ram.WEN   = 1'b1;
        ram.wdat  = sp.wdata[63:32];
        beat_addr = sp.addr + addr_t'(4);
      end
      DCACHE: begin
        ram.REN   = !dc.wen;
        ram.WEN   = dc.wen;
        ram.wdat  = dc.wdata;
        beat_addr = dc.addr;
      end
      ICACHE: begin
        ram.REN   = 1'b1;
        beat_addr = ic.addr;
      end
      default: begin
        beat_addr = '0;
      end
    endcase
  end

  // RAM is word addressed
  assign ram.sel = beat_addr >> 2;

  always_ff @(posedge CLK) begin
    if (state == SP_LOAD_LO && ram.ramhit) begin
      lo_q <= ram.rdat;
    end
  end

  // Done goes out with the final ramhit of an access
  assign sp.done = ram.ramhit && (state == SP_LOAD_HI || state == SP_STORE_HI);
  assign dc.done = ram.ramhit && (state == DCACHE);
  assign ic.done = ram.ramhit && (state == ICACHE);

  // High beat arrives last, low word comes from the held register
  assign sp.rdata = {ram.rdat, lo_q};
  assign dc.rdata = ram.rdat;
  assign ic.rdata = ram.rdat;

endmodule

`default_nettype wire

// File: design/ram_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_if
  import mem_arb_pkg::*;
();

  // Strobes, held until the ramhit cycle
  logic  REN;
  logic  WEN;
  // Word address and write data
  addr_t sel;
  word_t wdat;
  // Read data, valid while ramhit is high
  word_t rdat;
  logic  ramhit;

  modport arbiter (
    output REN, WEN, sel, wdat,
    input  rdat, ramhit
  );

  modport memory (
    input  REN, WEN, sel, wdat,
    output rdat, ramhit
  );

endinterface

`default_nettype wire

// File: design/req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface req_if
  import mem_arb_pkg::*;
#(
  parameter type data_t = word_t
) ();

  // Held from acceptance until done is seen
  logic  pending;
  logic  wen;
  addr_t addr;
  data_t wdata;

  // One-cycle completion pulse with read data
  logic  done;
  data_t rdata;

  modport port (
    output pending, wen, addr, wdata,
    input  done, rdata
  );

  modport arbiter (
    input  pending, wen, addr, wdata,
    output done, rdata
  );

endinterface

`default_nettype wire

// File: design/requester_port.sv
`timescale 1ns/1ps
`default_nettype none

module requester_port
  import mem_arb_pkg::*;
#(
  parameter type data_t = word_t
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  req,
  input  logic  wen,
  input  addr_t addr,
  input  data_t wdata,
  output data_t rdata,
  output logic  client_wait,
  req_if.port   link
);

  logic  busy;
  logic  accept;
  logic  wen_q;
  addr_t addr_q;
  data_t wdata_q;
  data_t rdata_q;

  // A new request is only taken while idle
  assign accept = req && !busy;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy    <= 1'b0;
      rdata_q <= '0;
    end else if (busy && link.done) begin
      busy <= 1'b0;
      // Keep the last read result for the client
      if (!wen_q) begin
        rdata_q <= link.rdata;
      end
    end else if (accept) begin
      busy <= 1'b1;
    end
  end

  // Request fields, stable for the whole access
  always_ff @(posedge CLK) begin
    if (accept) begin
      wen_q   <= wen;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign link.pending = busy;
  assign link.wen     = wen_q;
  assign link.addr    = addr_q;
  assign link.wdata   = wdata_q;

  assign client_wait = busy;
  assign rdata       = rdata_q;

endmodule

`default_nettype wire
